// File: Makefile
SRCS := $(filter-out +incdir+%,$(shell cat sources.f))

.PHONY: run clean

run: obj_dir/Vtb_arcade_shell
	@out="$$(./obj_dir/Vtb_arcade_shell)"; echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

obj_dir/Vtb_arcade_shell: sources.f $(SRCS) hw/arcade_settings.svh
	verilator --binary --assert -f sources.f --top-module tb_arcade_shell \
		-Mdir obj_dir -o Vtb_arcade_shell

clean:
	rm -rf obj_dir

// File: hw/arcade_pkg.sv
`default_nettype none

`include "arcade_settings.svh"

package arcade_pkg;

	typedef struct packed {
		logic       strobe; // toggles once per event
		logic       pressed;
		logic [7:0] code;
	} key_event_t;

	typedef struct packed {
		logic [1:0] spare;
		logic       bomb;
		logic       fire;
		logic       up;
		logic       down;
		logic       left;
		logic       right; // bit 0
	} joy_t;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic coin;
		logic start1;
		logic start2;
		logic fire1;
		logic fire2;
	} buttons_t;

	typedef struct packed {
		logic coin;
		logic start1;
		logic start2;
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire;
	} player_ctrl_t;

	typedef struct packed {
		logic [`ROM_ADDR_W-1:0] addr;
		logic [7:0]             data;
	} rom_wr_t;

	typedef struct packed {
		logic [2:0] r;
		logic [2:0] g;
		logic [1:0] b;
		logic       hblank;
		logic       vblank;
		logic       hs;
		logic       vs;
	} game_video_t;

	typedef struct packed {
		logic [5:0] r;
		logic [5:0] g;
		logic [5:0] b;
		logic       hs;
		logic       vs;
	} vga_t;

endpackage

`default_nettype wire

// File: hw/arcade_settings.svh
`ifndef ARCADE_SETTINGS_SVH
`define ARCADE_SETTINGS_SVH

// rom image
`define ROM_ADDR_W 15
`define ROM_DEPTH  32768

// audio path
`define SAMPLE_W 13
`define DAC_W    16 // sample is left-aligned into this

// ps/2 set 2 scan codes
`define KEY_UP     8'h75
`define KEY_DOWN   8'h72
`define KEY_LEFT   8'h6B
`define KEY_RIGHT  8'h74
`define KEY_COIN   8'h76 // esc
`define KEY_START1 8'h05 // f1
`define KEY_START2 8'h06 // f2
`define KEY_FIRE1  8'h29 // space
`define KEY_FIRE2  8'h11 // alt

`endif

// File: hw/arcade_shell.sv
`timescale 1ns/1ps
`default_nettype none

`include "arcade_settings.svh"

module arcade_shell (
	input  logic                     clock_48,
	input  logic                     rst_n,
	input  arcade_pkg::key_event_t   key_in,
	input  arcade_pkg::joy_t         joy0,
	input  arcade_pkg::joy_t         joy1,
	input  logic                     rotate,
	input  logic                     soft_reset,
	input  logic                     download,
	input  arcade_pkg::rom_wr_t      rom_wr,
	input  logic                     rom_wr_valid,
	output logic                     rom_wr_ready,
	input  logic [`ROM_ADDR_W-1:0]   rom_addr,
	input  logic                     rom_rd,
	output logic [7:0]               rom_data,
	output logic                     game_reset,
	output arcade_pkg::player_ctrl_t controls,
	input  arcade_pkg::game_video_t  game_video,
	output arcade_pkg::vga_t         vga,
	input  logic [`SAMPLE_W-1:0]     audio_sample,
	output logic                     audio_l,
	output logic                     audio_r
);

	arcade_pkg::buttons_t buttons;

	key_decoder i_key_decoder (
		.clock_48 (clock_48),
		.rst_n    (rst_n),
		.key_in   (key_in),
		.buttons  (buttons)
	);

	control_mapper i_control_mapper (
		.clock_48 (clock_48),
		.rst_n    (rst_n),
		.buttons  (buttons),
		.joy0     (joy0),
		.joy1     (joy1),
		.rotate   (rotate),
		.controls (controls)
	);

	rom_loader i_rom_loader (
		.clock_48     (clock_48),
		.rst_n        (rst_n),
		.download     (download),
		.rom_wr       (rom_wr),
		.rom_wr_valid (rom_wr_valid),
		.rom_wr_ready (rom_wr_ready),
		.rom_addr     (rom_addr),
		.rom_rd       (rom_rd),
		.rom_data     (rom_data),
		.soft_reset   (soft_reset),
		.game_reset   (game_reset)
	);

	video_out i_video_out (
		.clock_48   (clock_48),
		.rst_n      (rst_n),
		.game_video (game_video),
		.vga        (vga)
	);

	sigma_delta_dac i_sigma_delta_dac (
		.clock_48 (clock_48),
		.rst_n    (rst_n),
		.sample   (audio_sample),
		.dac      (audio_l)
	);

	assign audio_r = audio_l; // mono game sound

endmodule

`default_nettype wire

// File: hw/control_mapper.sv
`timescale 1ns/1ps
`default_nettype none

module control_mapper (
	input  logic                     clock_48,
	input  logic                     rst_n,
	input  arcade_pkg::buttons_t     buttons,
	input  arcade_pkg::joy_t         joy0,
	input  arcade_pkg::joy_t         joy1,
	input  logic                     rotate,
	output arcade_pkg::player_ctrl_t controls
);

	logic src_up;
	logic src_down;
	logic src_left;
	logic src_right;
	logic src_fire;
	logic src_bomb;

	// keyboard and both joysticks all steer the same player
	assign src_up    = buttons.up | joy0.up | joy1.up;
	assign src_down  = buttons.down | joy0.down | joy1.down;
	assign src_left  = buttons.left | joy0.left | joy1.left;
	assign src_right = buttons.right | joy0.right | joy1.right;
	assign src_fire  = buttons.fire1 | joy0.fire | joy1.fire;
	assign src_bomb  = buttons.fire2 | joy0.bomb | joy1.bomb;

	always_ff @(posedge clock_48) begin
		if (!rst_n) begin
			controls <= '0;
		end else begin
			controls.coin   <= buttons.coin;
			controls.start1 <= buttons.start1 | src_bomb; // start doubles as bomb
			controls.start2 <= buttons.start2 | src_bomb;
			controls.fire   <= src_fire;
			if (rotate) begin // screen turned by 90 degrees
				controls.up    <= src_left;
				controls.down  <= src_right;
				controls.left  <= src_down;
				controls.right <= src_up;
			end else begin
				controls.up    <= src_up;
				controls.down  <= src_down;
				controls.left  <= src_left;
				controls.right <= src_right;
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/key_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "arcade_settings.svh"

module key_decoder (
	input  logic                  clock_48,
	input  logic                  rst_n,
	input  arcade_pkg::key_event_t key_in,
	output arcade_pkg::buttons_t   buttons
);

	logic strobe_d;
	logic new_event;

	assign new_event = key_in.strobe != strobe_d; // any toggle is an event

	always_ff @(posedge clock_48) begin
		if (!rst_n) begin
			strobe_d <= 1'b0;
			buttons  <= '0;
		end else begin
			strobe_d <= key_in.strobe;
			if (new_event) begin
				case (key_in.code)
					`KEY_UP:
						buttons.up <= key_in.pressed;
					`KEY_DOWN:
						buttons.down <= key_in.pressed;
					`KEY_LEFT:
						buttons.left <= key_in.pressed;
					`KEY_RIGHT:
						buttons.right <= key_in.pressed;
					`KEY_COIN:
						buttons.coin <= key_in.pressed;
					`KEY_START1:
						buttons.start1 <= key_in.pressed;
					`KEY_START2:
						buttons.start2 <= key_in.pressed;
					`KEY_FIRE1:
						buttons.fire1 <= key_in.pressed;
					`KEY_FIRE2:
						buttons.fire2 <= key_in.pressed;
					default: begin
						// other keys are not mapped
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/rom_loader.sv
`timescale 1ns/1ps
`default_nettype none

`include "arcade_settings.svh"

module rom_loader (
	input  logic                   clock_48,
	input  logic                   rst_n,
	input  logic                   download,
	input  arcade_pkg::rom_wr_t    rom_wr,
	input  logic                   rom_wr_valid,
	output logic                   rom_wr_ready,
	input  logic [`ROM_ADDR_W-1:0] rom_addr,
	input  logic                   rom_rd,
	output logic [7:0]             rom_data,
	input  logic                   soft_reset,
	output logic                   game_reset
);

	logic [7:0] mem [`ROM_DEPTH];
	logic       download_d;
	logic       rom_loaded;
	logic       wr_fire;

	assign rom_wr_ready = download; // writes stall outside a download
	assign wr_fire      = rom_wr_valid & rom_wr_ready;

	always_ff @(posedge clock_48) begin
		if (wr_fire) begin
			mem[rom_wr.addr] <= rom_wr.data;
		end
	end

	// one cycle read for the game
	always_ff @(posedge clock_48) begin
		if (rom_rd && !download) begin
			rom_data <= mem[rom_addr];
		end
	end

	always_ff @(posedge clock_48) begin
		if (!rst_n) begin
			download_d <= 1'b0;
			rom_loaded <= 1'b0;
			game_reset <= 1'b1;
		end else begin
			download_d <= download;
			if (download_d && !download) begin
				rom_loaded <= 1'b1; // end of download
			end
			game_reset <= soft_reset | ~rom_loaded;
		end
	end

	// game stays in reset until the image is complete
	a_reset_until_loaded: assert property (
		@(posedge clock_48) disable iff (!rst_n)
		!rom_loaded |-> game_reset
	);

endmodule

`default_nettype wire

// File: hw/sigma_delta_dac.sv
`timescale 1ns/1ps
`default_nettype none

`include "arcade_settings.svh"

module sigma_delta_dac (
	input  logic                 clock_48,
	input  logic                 rst_n,
	input  logic [`SAMPLE_W-1:0] sample,
	output logic                 dac
);

	logic [`DAC_W-1:0] sample_wide;
	logic [`DAC_W-1:0] acc;
	logic [`DAC_W:0]   sum;

	assign sample_wide = {sample, {(`DAC_W - `SAMPLE_W){1'b0}}};
	assign sum         = {1'b0, acc} + {1'b0, sample_wide};

	always_ff @(posedge clock_48) begin
		if (!rst_n) begin
			acc <= '0;
			dac <= 1'b0;
		end else begin
			acc <= sum[`DAC_W-1:0];
			dac <= sum[`DAC_W]; // carry is the pulse
		end
	end

endmodule

`default_nettype wire

// File: hw/video_out.sv
`timescale 1ns/1ps
`default_nettype none

module video_out (
	input  logic                    clock_48,
	input  logic                    rst_n,
	input  arcade_pkg::game_video_t game_video,
	output arcade_pkg::vga_t        vga
);

	logic       blank;
	logic [2:0] blue3;

	assign blank = game_video.hblank | game_video.vblank;
	assign blue3 = {game_video.b, game_video.b[0]}; // 2 to 3 bits

	always_ff @(posedge clock_48) begin
		if (!rst_n) begin
			vga <= '0;
		end else begin
			vga.hs <= game_video.hs; // sync follows color
			vga.vs <= game_video.vs;
			if (blank) begin
				vga.r <= '0;
				vga.g <= '0;
				vga.b <= '0;
			end else begin
				vga.r <= {game_video.r, game_video.r};
				vga.g <= {game_video.g, game_video.g};
				vga.b <= {blue3, blue3};
			end
		end
	end

	// blanking reaches the vga pins one cycle later
	a_blank_black: assert property (
		@(posedge clock_48) disable iff (!rst_n)
		blank |=> (vga.r == '0 && vga.g == '0 && vga.b == '0)
	);

endmodule

`default_nettype wire

// File: sources.f
+incdir+hw
hw/arcade_pkg.sv
hw/key_decoder.sv
hw/control_mapper.sv
hw/rom_loader.sv
hw/video_out.sv
hw/sigma_delta_dac.sv
hw/arcade_shell.sv
tb/tb_arcade_shell.sv

// File: tb/tb_arcade_shell.sv
`timescale 1ns/1ps
`default_nettype none

`include "arcade_settings.svh"

module tb_arcade_shell;

	localparam int TIMEOUT_CYCLES = 6000; // tests need about 800 cycles

	logic                     clock_48;
	logic                     rst_n;
	arcade_pkg::key_event_t   key_in;
	arcade_pkg::joy_t         joy0;
	arcade_pkg::joy_t         joy1;
	logic                     rotate;
	logic                     soft_reset;
	logic                     download;
	arcade_pkg::rom_wr_t      rom_wr;
	logic                     rom_wr_valid;
	logic                     rom_wr_ready;
	logic [`ROM_ADDR_W-1:0]   rom_addr;
	logic                     rom_rd;
	logic [7:0]               rom_data;
	logic                     game_reset;
	arcade_pkg::player_ctrl_t controls;
	arcade_pkg::game_video_t  game_video;
	arcade_pkg::vga_t         vga;
	logic [`SAMPLE_W-1:0]     audio_sample;
	logic                     audio_l;
	logic                     audio_r;

	logic [31:0]            lcg_state = 32'd44;
	int                     cycle_count = 0;
	logic [`ROM_ADDR_W-1:0] wr_addr [64];
	logic [7:0]             rom_model [`ROM_DEPTH]; // expected rom contents

	arcade_shell i_dut (.*);

	initial begin
		clock_48 = 1'b0;
		forever #4 clock_48 = ~clock_48;
	end

	always @(posedge clock_48) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			abort_run("the run did not finish within the cycle limit");
		end
	end

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		assert (got == expected) else begin
			abort_run($sformatf("ERR %s got %h expected %h", name, got, expected));
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clock_48);
		@(negedge clock_48); // outputs settled here
	endtask

	// bit order coin start1 start2 up down left right fire
	function automatic logic [7:0] key_control(input logic [7:0] code);
		case (code)
			`KEY_UP:     return 8'h10;
			`KEY_DOWN:   return 8'h08;
			`KEY_LEFT:   return 8'h04;
			`KEY_RIGHT:  return 8'h02;
			`KEY_COIN:   return 8'h80;
			`KEY_START1: return 8'h40;
			`KEY_START2: return 8'h20;
			`KEY_FIRE1:  return 8'h01;
			default:     return 8'h60; // fire2 presses both starts
		endcase
	endfunction

	function automatic logic [7:0] joy_control(input int bit_idx, input logic rot);
		case (bit_idx)
			0:       return rot ? 8'h08 : 8'h02; // right turns into down
			1:       return rot ? 8'h10 : 8'h04; // left turns into up
			2:       return rot ? 8'h04 : 8'h08; // down turns into left
			3:       return rot ? 8'h02 : 8'h10; // up turns into right
			4:       return 8'h01;
			default: return 8'h60; // bomb
		endcase
	endfunction

	function automatic arcade_pkg::vga_t expand_video(input arcade_pkg::game_video_t gv);
		arcade_pkg::vga_t v;
		logic [2:0]       b3;
		b3   = gv.b * 3'd2 + 3'(gv.b[0]);
		v    = '0;
		v.hs = gv.hs;
		v.vs = gv.vs;
		if (!gv.hblank && !gv.vblank) begin
			v.r = 6'(gv.r) * 6'd9; // repeating 3 bits is a multiply by 9
			v.g = 6'(gv.g) * 6'd9;
			v.b = 6'(b3) * 6'd9;
		end
		return v;
	endfunction

	task automatic rom_write(input logic [`ROM_ADDR_W-1:0] addr, input logic [7:0] data);
		@(posedge clock_48);
		rom_wr       <= {addr, data};
		rom_wr_valid <= 1'b1;
		@(negedge clock_48);
		while (!rom_wr_ready) begin
			@(negedge clock_48);
		end
		@(posedge clock_48); // accepted on this edge
		rom_wr_valid <= 1'b0;
	endtask

	task automatic send_key(input logic [7:0] code, input logic pressed);
		@(posedge clock_48);
		key_in <= {~key_in.strobe, pressed, code};
		wait_cycles(2);
	endtask

	task automatic reset_and_load();
		logic [31:0] r;
		int          waited;
		wait_cycles(1);
		check_value("game_reset", 32'(game_reset), 32'd1);
		check_value("vga", 32'(vga), 32'd0);
		check_value("controls", 32'(controls), 32'd0);
		check_value("audio_l", 32'(audio_l), 32'd0);
		@(posedge clock_48);
		r = next_random();
		rom_wr       <= r[30:8];
		rom_wr_valid <= 1'b1;
		repeat (4) begin
			@(negedge clock_48);
			check_value("rom_wr_ready", 32'(rom_wr_ready), 32'd0);
		end
		@(posedge clock_48);
		rom_wr_valid <= 1'b0;
		download     <= 1'b1;
		for (int i = 0; i < 64; i++) begin
			r          = next_random();
			wr_addr[i] = r[30:16];
			r          = next_random();
			rom_model[wr_addr[i]] = r[30:23];
			rom_write(wr_addr[i], r[30:23]);
		end
		@(posedge clock_48);
		download <= 1'b0;
		waited = 0;
		@(negedge clock_48);
		while (game_reset && waited < 2) begin
			@(negedge clock_48);
			waited++;
		end
		assert (!game_reset) else begin
			abort_run("game_reset still high two cycles after the download ended");
		end
	endtask

	task automatic rom_readback();
		for (int i = 0; i < 64; i++) begin
			@(posedge clock_48);
			rom_addr <= wr_addr[i];
			rom_rd   <= 1'b1;
			wait_cycles(1);
			check_value("rom_data", 32'(rom_data), 32'(rom_model[wr_addr[i]]));
		end
		@(posedge clock_48);
		rom_rd     <= 1'b0;
		soft_reset <= 1'b1;
		wait_cycles(1);
		check_value("game_reset", 32'(game_reset), 32'd1);
		@(posedge clock_48);
		soft_reset <= 1'b0;
		wait_cycles(1);
		check_value("game_reset", 32'(game_reset), 32'd0);
	endtask

	task automatic keyboard_keys();
		logic [7:0] codes [9];
		codes = '{`KEY_UP, `KEY_DOWN, `KEY_LEFT, `KEY_RIGHT, `KEY_COIN,
			`KEY_START1, `KEY_START2, `KEY_FIRE1, `KEY_FIRE2};
		for (int i = 0; i < 9; i++) begin
			send_key(codes[i], 1'b1);
			check_value("controls", 32'(controls), 32'(key_control(codes[i])));
			send_key(codes[i], 1'b0);
			check_value("controls", 32'(controls), 32'd0);
		end
		send_key(`KEY_UP, 1'b1);
		send_key(8'h1C, 1'b0); // unmapped key must not touch up
		check_value("controls", 32'(controls), 32'(key_control(`KEY_UP)));
		send_key(8'h1C, 1'b1);
		check_value("controls", 32'(controls), 32'(key_control(`KEY_UP)));
		send_key(`KEY_UP, 1'b0);
		check_value("controls", 32'(controls), 32'd0);
	endtask

	task automatic joystick_rotation();
		logic [7:0] stick;
		for (int rot = 0; rot < 2; rot++) begin
			for (int j = 0; j < 2; j++) begin
				for (int b = 0; b < 6; b++) begin
					stick = 8'b1 << b;
					@(posedge clock_48);
					rotate <= rot[0];
					joy0   <= (j == 0) ? stick : 8'h00;
					joy1   <= (j == 1) ? stick : 8'h00;
					wait_cycles(1);
					check_value("controls", 32'(controls), 32'(joy_control(b, rot[0])));
					@(posedge clock_48);
					joy0 <= '0;
					joy1 <= '0;
					wait_cycles(1);
					check_value("controls", 32'(controls), 32'd0);
				end
			end
		end
		@(posedge clock_48);
		rotate <= 1'b0;
	endtask

	task automatic video_expansion();
		logic [31:0]             r;
		arcade_pkg::game_video_t gv;
		for (int i = 0; i < 32; i++) begin
			r         = next_random();
			gv        = r[27:16];
			gv.hblank = i[0];
			gv.vblank = i[1];
			@(posedge clock_48);
			game_video <= gv;
			wait_cycles(1);
			check_value("vga", 32'(vga), 32'(expand_video(gv)));
		end
		@(posedge clock_48);
		game_video <= '0;
	endtask

	task automatic audio_density();
		int ones;
		ones = 0;
		@(posedge clock_48);
		audio_sample <= 13'h800;
		@(negedge clock_48); // modulator has not seen the sample yet
		repeat (256) begin
			@(negedge clock_48);
			if (audio_l) begin
				ones++;
			end
			check_value("audio_r", 32'(audio_r), 32'(audio_l));
		end
		check_value("audio_l ones", 32'(ones), 32'd64);
	endtask

	initial begin
		rst_n        = 1'b0;
		key_in       = '0;
		joy0         = '0;
		joy1         = '0;
		rotate       = 1'b0;
		soft_reset   = 1'b0;
		download     = 1'b0;
		rom_wr       = '0;
		rom_wr_valid = 1'b0;
		rom_addr     = '0;
		rom_rd       = 1'b0;
		game_video   = '0;
		audio_sample = '0;
		repeat (16) @(posedge clock_48);
		rst_n <= 1'b1;
		reset_and_load();
		rom_readback();
		keyboard_keys();
		joystick_rotation();
		video_expansion();
		audio_density();
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire
